//--- cpubus_defs.svh
`ifndef CPUBUS_DEFS_SVH
`define CPUBUS_DEFS_SVH

// width of the byte address on both the cpu side and the wishbone side
`define CPUBUS_ADDR_W 32

// on-chip ram size in bytes, power of two
// higher address bits are ignored so accesses wrap
`define CPUBUS_RAM_BYTES 1024

// cycles from a strobe to its ack, must be at least 1
`define CPUBUS_ACK_LAT 2

`endif

//--- busop_pkg.sv
`include "cpubus_defs.svh"

package busop_pkg;

	// cpu side bus operations
	// idle code needs a 9th value, hence 4 bits
	typedef enum logic [3:0] {
		BUSOP_IDLE   = 4'd0,
		BUSOP_READB  = 4'd1,	// signed byte
		BUSOP_READBU = 4'd2,	// unsigned byte
		BUSOP_READH  = 4'd3,	// signed half
		BUSOP_READHU = 4'd4,	// unsigned half
		BUSOP_READW  = 4'd5,
		BUSOP_WRITEB = 4'd6,
		BUSOP_WRITEH = 4'd7,
		BUSOP_WRITEW = 4'd8
	} bus_op_t;

	// request from a port, valid is a one cycle strobe
	typedef struct packed {
		logic                      valid;
		bus_op_t                   op;
		logic [`CPUBUS_ADDR_W-1:0] addr;
		logic [31:0]               wdata;	// little endian, low byte first on the bus
	} bus_req_t;

	// completion back to a port
	typedef struct packed {
		logic        done;	// one cycle strobe
		logic [31:0] rdata;	// only meaningful for reads
	} bus_rsp_t;

endpackage

//--- wb_pkg.sv
`include "cpubus_defs.svh"

package wb_pkg;

	// master to slave signals of the 8-bit wishbone bus
	typedef struct packed {
		logic [`CPUBUS_ADDR_W-1:0] adr;
		logic [7:0]                dat;
		logic                      cyc;
		logic                      stb;
		logic                      we;
	} wb_m2s_t;

	// slave to master signals
	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_s2m_t;

endpackage

//--- bus_wb8_pipelined.sv
`include "cpubus_defs.svh"

module bus_wb8_pipelined
	import busop_pkg::*;
	import wb_pkg::*;
(
	input  logic        CLK_I,
	input  logic        RST_I,
	input  logic        start,
	input  bus_req_t    req,
	output logic        done,
	output logic [31:0] rdata,
	output wb_m2s_t     wb_o,
	input  wb_s2m_t     wb_i
);

	typedef enum logic {
		ST_IDLE,
		ST_ACTIVE
	} state_t;

	state_t state;

	// decoded view of the incoming op
	logic [2:0] op_bytes;
	logic       op_write;
	logic       op_signed;

	// transaction held for the whole burst
	logic [2:0]                byte_n;
	logic                      sgn;
	logic [`CPUBUS_ADDR_W-1:0] base_addr;
	logic [31:0]               wdata_q;

	logic [2:0]  addrcnt;	// strobes issued
	logic [2:0]  ackcnt;	// acks received
	logic [31:0] rbuf;
	logic        done_q;
	wb_m2s_t     m2s_q;

	logic ack_sign;
	logic last_ack;
	logic [7:0] next_wbyte;

	always_comb begin
		op_bytes  = 3'd0;
		op_write  = 1'b0;
		op_signed = 1'b0;
		case (req.op)
			BUSOP_READB: begin
				op_bytes  = 3'd1;
				op_signed = 1'b1;
			end
			BUSOP_READBU: op_bytes = 3'd1;
			BUSOP_READH: begin
				op_bytes  = 3'd2;
				op_signed = 1'b1;
			end
			BUSOP_READHU: op_bytes = 3'd2;
			BUSOP_READW:  op_bytes = 3'd4;
			BUSOP_WRITEB: begin
				op_bytes = 3'd1;
				op_write = 1'b1;
			end
			BUSOP_WRITEH: begin
				op_bytes = 3'd2;
				op_write = 1'b1;
			end
			BUSOP_WRITEW: begin
				op_bytes = 3'd4;
				op_write = 1'b1;
			end
			default: op_bytes = 3'd0;	// idle, completes without bus traffic
		endcase
	end

	assign ack_sign = wb_i.dat[7] & sgn;
	assign last_ack = wb_i.ack && ((ackcnt + 3'd1) == byte_n);

	// write byte for the next strobe
	always_comb begin
		case (addrcnt[1:0])
			2'd0:    next_wbyte = wdata_q[7:0];
			2'd1:    next_wbyte = wdata_q[15:8];
			2'd2:    next_wbyte = wdata_q[23:16];
			default: next_wbyte = wdata_q[31:24];
		endcase
	end

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			state     <= ST_IDLE;
			done_q    <= 1'b0;
			addrcnt   <= 3'd0;
			ackcnt    <= 3'd0;
			m2s_q.cyc <= 1'b0;
			m2s_q.stb <= 1'b0;
			m2s_q.we  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start && req.valid) begin
						byte_n    <= op_bytes;
						sgn       <= op_signed;
						base_addr <= req.addr;
						wdata_q   <= req.wdata;
						ackcnt    <= 3'd0;
						if (op_bytes == 3'd0) begin
							rbuf   <= 32'd0;
							done_q <= 1'b1;
						end else begin
							// first strobe goes out right away
							m2s_q.cyc <= 1'b1;
							m2s_q.stb <= 1'b1;
							m2s_q.we  <= op_write;
							m2s_q.adr <= req.addr;
							m2s_q.dat <= req.wdata[7:0];
							addrcnt   <= 3'd1;
							state     <= ST_ACTIVE;
						end
					end
				end
				ST_ACTIVE: begin
					// issue without waiting for acks
					if (addrcnt != byte_n) begin
						m2s_q.stb <= 1'b1;
						m2s_q.adr <= base_addr + `CPUBUS_ADDR_W'(addrcnt);
						m2s_q.dat <= next_wbyte;
						addrcnt   <= addrcnt + 3'd1;
					end else begin
						m2s_q.stb <= 1'b0;
					end

					if (wb_i.ack) begin
						case (ackcnt[1:0])
							2'd0:    rbuf <= {{24{ack_sign}}, wb_i.dat};
							2'd1:    rbuf[31:8] <= {{16{ack_sign}}, wb_i.dat};
							2'd2:    rbuf[23:16] <= wb_i.dat;
							default: rbuf[31:24] <= wb_i.dat;
						endcase
						ackcnt <= ackcnt + 3'd1;
					end

					if (last_ack) begin
						m2s_q.cyc <= 1'b0;
						m2s_q.stb <= 1'b0;
						m2s_q.we  <= 1'b0;
						done_q    <= 1'b1;
						state     <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign wb_o  = m2s_q;
	assign done  = done_q;
	assign rdata = rbuf;

endmodule

//--- bus_arbiter.sv
module bus_arbiter
	import busop_pkg::*;
(
	input  logic        CLK_I,
	input  logic        RST_I,
	input  bus_req_t    fetch_req,
	input  bus_req_t    data_req,
	output bus_rsp_t    fetch_rsp,
	output bus_rsp_t    data_rsp,
	output logic        start,
	output bus_req_t    mreq,
	input  logic        mdone,
	input  logic [31:0] mrdata
);

	// one pending slot per port
	logic     pend_f;
	logic     pend_d;
	bus_req_t hold_f;
	bus_req_t hold_d;

	logic busy;		// bus master owns a transaction
	logic owner_d;	// current owner is the data port
	logic last_d;	// data port was served last

	logic grant_d;
	logic fin_f;
	logic fin_d;

	// both pending goes to whoever was not served last
	assign grant_d = pend_d && (!pend_f || !last_d);
	assign start   = !busy && (pend_f || pend_d);

	always_comb begin
		mreq       = grant_d ? hold_d : hold_f;
		mreq.valid = start;
	end

	// completion goes straight back to the owner
	assign fin_f = mdone && busy && !owner_d;
	assign fin_d = mdone && busy && owner_d;

	assign fetch_rsp.done  = fin_f;
	assign fetch_rsp.rdata = mrdata;
	assign data_rsp.done   = fin_d;
	assign data_rsp.rdata  = mrdata;

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			pend_f  <= 1'b0;
			pend_d  <= 1'b0;
			busy    <= 1'b0;
			owner_d <= 1'b0;
			last_d  <= 1'b0;
		end else begin
			if (start) begin
				busy    <= 1'b1;
				owner_d <= grant_d;
				last_d  <= grant_d;
			end
			if (mdone)
				busy <= 1'b0;

			if (fin_f)
				pend_f <= 1'b0;
			if (fin_d)
				pend_d <= 1'b0;

			// a new request wins over the clear of the old one
			if (fetch_req.valid)
				pend_f <= 1'b1;
			if (data_req.valid)
				pend_d <= 1'b1;
		end
	end

	always_ff @(posedge CLK_I) begin
		if (fetch_req.valid)
			hold_f <= fetch_req;
		if (data_req.valid)
			hold_d <= data_req;
	end

endmodule

//--- wb8_ram.sv
`include "cpubus_defs.svh"

module wb8_ram
	import wb_pkg::*;
(
	input  logic    CLK_I,
	input  logic    RST_I,
	input  wb_m2s_t wb_i,
	output wb_s2m_t wb_o
);

	localparam int IDX_W = $clog2(`CPUBUS_RAM_BYTES);
	localparam int LAT   = `CPUBUS_ACK_LAT;

	logic [7:0] mem [`CPUBUS_RAM_BYTES];

	logic [IDX_W-1:0] idx;
	logic             hit;

	// ack and read data travel together down the pipe
	logic [LAT-1:0] ack_pipe;
	logic [7:0]     dat_pipe [LAT];

	assign idx = wb_i.adr[IDX_W-1:0];	// upper bits dropped, addresses wrap
	assign hit = wb_i.cyc && wb_i.stb;

	initial begin
		for (int i = 0; i < `CPUBUS_RAM_BYTES; i++)
			mem[i] = 8'h00;
	end

	always_ff @(posedge CLK_I) begin
		if (hit && wb_i.we)
			mem[idx] <= wb_i.dat;
	end

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			ack_pipe <= '0;
		end else begin
			ack_pipe[0] <= hit;
			for (int i = 1; i < LAT; i++)
				ack_pipe[i] <= ack_pipe[i-1];
		end
	end

	always_ff @(posedge CLK_I) begin
		dat_pipe[0] <= mem[idx];	// old contents on a write strobe
		for (int i = 1; i < LAT; i++)
			dat_pipe[i] <= dat_pipe[i-1];
	end

	assign wb_o.ack = ack_pipe[LAT-1];
	assign wb_o.dat = dat_pipe[LAT-1];

endmodule

//--- cpubus_top.sv
module cpubus_top
	import busop_pkg::*;
	import wb_pkg::*;
(
	input  logic     CLK_I,
	input  logic     RST_I,
	input  bus_req_t fetch_req,
	input  bus_req_t data_req,
	output bus_rsp_t fetch_rsp,
	output bus_rsp_t data_rsp
);

	// arbiter to bus master
	logic        start;
	bus_req_t    mreq;
	logic        mdone;
	logic [31:0] mrdata;

	// bus master to ram
	wb_m2s_t m2s;
	wb_s2m_t s2m;

	bus_arbiter arb0 (
		.CLK_I     (CLK_I),
		.RST_I     (RST_I),
		.fetch_req (fetch_req),
		.data_req  (data_req),
		.fetch_rsp (fetch_rsp),
		.data_rsp  (data_rsp),
		.start     (start),
		.mreq      (mreq),
		.mdone     (mdone),
		.mrdata    (mrdata)
	);

	bus_wb8_pipelined bus0 (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.start (start),
		.req   (mreq),
		.done  (mdone),
		.rdata (mrdata),
		.wb_o  (m2s),
		.wb_i  (s2m)
	);

	wb8_ram ram0 (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.wb_i  (m2s),
		.wb_o  (s2m)
	);

endmodule

//--- cpubus_sva.sv
module cpubus_sva
	import wb_pkg::*;
(
	input logic    CLK_I,
	input logic    RST_I,
	input logic    done,
	input wb_m2s_t wb_o,
	input wb_s2m_t wb_i
);

	int fail_cnt = 0;	// read by the testbench top for the final verdict

	stb_in_cycle: assert property (@(posedge CLK_I) disable iff (RST_I) wb_o.stb |-> wb_o.cyc)
		else begin
			$error("stb high outside a bus cycle");
			fail_cnt++;
		end

	ack_in_cycle: assert property (@(posedge CLK_I) disable iff (RST_I) wb_i.ack |-> wb_o.cyc)
		else begin
			$error("ack high outside a bus cycle");
			fail_cnt++;
		end

	// direction may only change between bus cycles
	we_steady: assert property (@(posedge CLK_I) disable iff (RST_I)
		(wb_o.cyc && $past(wb_o.cyc)) |-> (wb_o.we == $past(wb_o.we)))
		else begin
			$error("we changed inside a bus cycle");
			fail_cnt++;
		end

	done_single: assert property (@(posedge CLK_I) disable iff (RST_I) done |=> !done)
		else begin
			$error("done high in two consecutive cycles");
			fail_cnt++;
		end

endmodule

//--- cpubus_monitor.sv
`include "cpubus_defs.svh"

module cpubus_monitor
	import busop_pkg::*;
(
	input  logic     CLK_I,
	input  logic     RST_I,
	input  bus_req_t fetch_req,
	input  bus_req_t data_req,
	input  bus_rsp_t fetch_rsp,
	input  bus_rsp_t data_rsp,
	output int       value_errs,
	output int       proto_errs,
	output int       done_cnt
);

	localparam int IDX_W    = $clog2(`CPUBUS_RAM_BYTES);
	localparam int MAX_WAIT = 2 * (4 + `CPUBUS_ACK_LAT + 1) + 2;	// worst case valid to done

	logic [7:0] model [`CPUBUS_RAM_BYTES];
	bus_req_t   open_req [2];	// 0 is fetch, 1 is data
	logic       open_flag [2];
	int         age [2];
	int         verr = 0;
	int         perr = 0;
	int         dcnt = 0;

	function automatic logic [IDX_W-1:0] wrap(logic [31:0] addr, int k);
		logic [31:0] a;
		a = addr + 32'(k);
		return a[IDX_W-1:0];
	endfunction

	// little endian word from addr upward, then narrowed by the op
	function automatic logic [31:0] expected_read(bus_req_t r);
		logic [31:0] w;
		w = {model[wrap(r.addr, 3)], model[wrap(r.addr, 2)],
			model[wrap(r.addr, 1)], model[wrap(r.addr, 0)]};
		case (r.op)
			BUSOP_READB:  return {{24{w[7]}}, w[7:0]};
			BUSOP_READBU: return {24'd0, w[7:0]};
			BUSOP_READH:  return {{16{w[15]}}, w[15:0]};
			BUSOP_READHU: return {16'd0, w[15:0]};
			default:      return w;
		endcase
	endfunction

	function automatic int write_len(bus_op_t op);
		case (op)
			BUSOP_WRITEB: return 1;
			BUSOP_WRITEH: return 2;
			BUSOP_WRITEW: return 4;
			default:      return 0;
		endcase
	endfunction

	task automatic check_port(input int p, input bus_req_t req, input bus_rsp_t rsp,
		input string name);
		bus_req_t    r;
		logic [31:0] exp;
		int          n;
		r = open_req[p];
		if (rsp.done) begin
			dcnt++;
			if (!open_flag[p]) begin
				$display("%s port: done arrived with no request open", name);
				perr++;
			end else begin
				n = write_len(r.op);
				for (int k = 0; k < n; k++)
					model[wrap(r.addr, k)] = r.wdata[8*k +: 8];	// takes effect at done
				exp = expected_read(r);
				if (n == 0 && rsp.rdata !== exp) begin
					$display("[ERROR] %s_rsp.rdata expected 0x%h got 0x%h (%s at 0x%h)",
						name, exp, rsp.rdata, r.op.name(), r.addr);
					verr++;
				end
				open_flag[p] = 1'b0;
			end
		end
		if (open_flag[p]) begin
			age[p]++;
			if (age[p] == MAX_WAIT) begin
				$display("%s port: request at 0x%h got no done within %0d cycles",
					name, r.addr, MAX_WAIT);
				perr++;
			end
		end
		if (req.valid) begin
			open_req[p]  = req;
			open_flag[p] = 1'b1;
			age[p]       = 0;
		end
	endtask

	// sampled mid cycle, away from the driving edge
	always @(negedge CLK_I) begin
		if (RST_I) begin
			if (fetch_rsp.done || data_rsp.done) begin
				$display("done seen on a port while reset is high");
				perr++;
			end
			for (int i = 0; i < `CPUBUS_RAM_BYTES; i++)
				model[i] = 8'h00;	// ram comes up zero
			for (int p = 0; p < 2; p++) begin
				open_flag[p] = 1'b0;
				age[p]       = 0;
			end
		end else begin
			check_port(0, fetch_req, fetch_rsp, "fetch");
			check_port(1, data_req, data_rsp, "data");
		end
	end

	assign value_errs = verr;
	assign proto_errs = perr;
	assign done_cnt   = dcnt;

endmodule

//--- cpubus_tb.sv
`include "cpubus_defs.svh"

module cpubus_tb
	import busop_pkg::*;
();

	localparam int N_PER_PORT     = 400;
	localparam int TIMEOUT_CYCLES = 2 * N_PER_PORT * (4 + `CPUBUS_ACK_LAT + 1) * 2;

	logic     CLK_I = 1'b0;
	logic     RST_I;
	bus_req_t fetch_req;
	bus_req_t data_req;
	bus_rsp_t fetch_rsp;
	bus_rsp_t data_rsp;

	int value_errs;
	int proto_errs;
	int done_cnt;
	int assert_errs;

	logic [15:0] lfsr = 16'd53;
	logic        fetch_wait;
	logic        data_wait;
	int          fetch_sent;
	int          data_sent;
	int          fetch_seen;
	int          data_seen;
	int          cycle_cnt;
	logic        timed_out;

	always #4 CLK_I = ~CLK_I;

	cpubus_top dut0 (
		.CLK_I     (CLK_I),
		.RST_I     (RST_I),
		.fetch_req (fetch_req),
		.data_req  (data_req),
		.fetch_rsp (fetch_rsp),
		.data_rsp  (data_rsp)
	);

	cpubus_monitor chk0 (
		.CLK_I      (CLK_I),
		.RST_I      (RST_I),
		.fetch_req  (fetch_req),
		.data_req   (data_req),
		.fetch_rsp  (fetch_rsp),
		.data_rsp   (data_rsp),
		.value_errs (value_errs),
		.proto_errs (proto_errs),
		.done_cnt   (done_cnt)
	);

	bind bus_wb8_pipelined cpubus_sva sva0 (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.done  (done),
		.wb_o  (wb_o),
		.wb_i  (wb_i)
	);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic make_request(input logic reads_only, output bus_req_t r);
		logic [31:0] v;
		r       = '0;
		r.valid = 1'b1;
		take_bits(3, v);
		if (reads_only)
			r.op = bus_op_t'(4'(v % 5 + 1));	// READB .. READW
		else
			r.op = bus_op_t'(4'(v + 1));
		take_bits(10, v);
		r.addr = v;	// near the top it wraps past the ram end
		take_bits(32, v);
		r.wdata = v;
	endtask

	task automatic drive_port(input logic reads_only, input logic done, inout logic waiting,
		inout int sent, inout int seen, output bus_req_t r);
		logic [31:0] v;
		r = '0;
		if (waiting && done) begin
			waiting = 1'b0;
			seen++;
		end
		if (!waiting && sent < N_PER_PORT) begin
			take_bits(2, v);
			if (v[1:0] != 2'b00) begin	// issue three times in four
				make_request(reads_only, r);
				waiting = 1'b1;
				sent++;
			end
		end
	endtask

	initial begin
		RST_I      = 1'b1;
		fetch_req  = '0;
		data_req   = '0;
		fetch_wait = 1'b0;
		data_wait  = 1'b0;
		fetch_sent = 0;
		data_sent  = 0;
		fetch_seen = 0;
		data_seen  = 0;
		cycle_cnt  = 0;
		repeat (8) @(posedge CLK_I);
		#1;
		RST_I = 1'b0;
		repeat (4) @(posedge CLK_I);	// quiet ports, no done expected here

		while ((fetch_seen < N_PER_PORT || data_seen < N_PER_PORT)
			&& cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge CLK_I);
			#1;
			cycle_cnt++;
			drive_port(1'b1, fetch_rsp.done, fetch_wait, fetch_sent, fetch_seen, fetch_req);
			drive_port(1'b0, data_rsp.done, data_wait, data_sent, data_seen, data_req);
		end
		timed_out = (fetch_seen < N_PER_PORT || data_seen < N_PER_PORT);
		repeat (3) @(posedge CLK_I);

		assert_errs = dut0.bus0.sva0.fail_cnt;
		if (timed_out)
			$display("timeout: not all transactions completed within %0d cycles", TIMEOUT_CYCLES);
		$display("errors: %0d value, %0d protocol, %0d assertion; %0d of %0d dones seen",
			value_errs, proto_errs, assert_errs, done_cnt, 2 * N_PER_PORT);
		if (timed_out || value_errs != 0 || proto_errs != 0 || assert_errs != 0)
			$display("Simulation FAILED");
		else
			$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- cpubus.f
+incdir+.
busop_pkg.sv
wb_pkg.sv
bus_wb8_pipelined.sv
bus_arbiter.sv
wb8_ram.sv
cpubus_top.sv
cpubus_sva.sv
cpubus_monitor.sv
cpubus_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cpubus testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 --top-module cpubus_tb -f cpubus.f -o cpubus_sim

./obj_dir/cpubus_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation PASSED$" sim.log; then
	exit 0
fi
echo "run failed, see sim.log"
exit 1
